// File: verilog/core_cfg_pkg.sv
// Core sizing for the two-bus RV32I core.
// One word is the only data size, and the register file has no write bypass.

package core_cfg_pkg;

	localparam int xlen = 32; // Data and address width
	localparam int reg_count = 32;
	localparam int reg_addr_w = 5; // Index width for reg_count entries

	typedef logic [xlen-1:0] word_t;

	localparam word_t reset_vector = '0; // First ROM address after reset

endpackage

// File: verilog/rv_isa_pkg.sv
// RV32I encodings used by the core.
// Only the base integer subset is listed. No compressed, M or system codes.

package rv_isa_pkg;

	// Major opcodes, instr[6:0]
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;

	// Branch conditions
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [2:0] f3_blt = 3'b100;
	localparam logic [2:0] f3_bge = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// ALU operations
	localparam logic [2:0] f3_add = 3'b000; // Also sub with funct7[5]
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_sr = 3'b101; // srl or sra by funct7[5]
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;

	// Load/store width, only full words are supported
	localparam logic [2:0] f3_word = 3'b010;

endpackage

// File: verilog/reg_file.sv
// Integer register file with asynchronous reads.
// There is no write-to-read bypass. A write becomes visible the cycle after.

module reg_file
	import core_cfg_pkg::*;
(
	input logic clk,
	input logic [reg_addr_w-1:0] rs1_idx,
	input logic [reg_addr_w-1:0] rs2_idx,
	input logic [reg_addr_w-1:0] rd_idx,
	input word_t rd_data,
	input logic rd_we,
	output word_t rs1_val,
	output word_t rs2_val
);

	word_t regs [reg_count];

	assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx]; // x0 is hardwired
	assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

	always_ff @(posedge clk)
	begin
		if (rd_we && rd_idx != '0)
			regs[rd_idx] <= rd_data;
	end

endmodule

// File: verilog/alu.sv
// Integer ALU for the OP and OP-IMM groups, plus branch compare flags.
// Shift amounts use the low five bits only. The flags always compare rs1 with rs2.

module alu
	import core_cfg_pkg::*;
	import rv_isa_pkg::*;
(
	input word_t instr,
	input word_t rs1_val,
	input word_t rs2_val,
	output word_t result,
	output logic eq,
	output logic lt,
	output logic ltu
);

	word_t imm_i;
	word_t op_b;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt; // funct7[5], selects sub and sra
	logic [4:0] shamt;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign alt = instr[30];
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign op_b = (opcode == op_imm) ? imm_i : rs2_val;
	assign shamt = op_b[4:0];

	assign eq = (rs1_val == rs2_val);
	assign lt = ($signed(rs1_val) < $signed(rs2_val));
	assign ltu = (rs1_val < rs2_val);

	always_comb
	begin
		case (funct3)
			f3_add:
				if (opcode == op_reg && alt)
					result = rs1_val - op_b;
				else
					result = rs1_val + op_b; // addi has no subtract form
			f3_sll: result = rs1_val << shamt;
			f3_slt: result = {31'd0, $signed(rs1_val) < $signed(op_b)};
			f3_sltu: result = {31'd0, rs1_val < op_b};
			f3_xor: result = rs1_val ^ op_b;
			f3_sr:
				if (alt)
					result = word_t'($signed(rs1_val) >>> shamt);
				else
					result = rs1_val >> shamt;
			f3_or: result = rs1_val | op_b;
			f3_and: result = rs1_val & op_b;
			default: result = '0;
		endcase
	end

endmodule

// File: verilog/fetch_stage.sv
// Fetch stage for a synchronous ROM with one cycle of read latency.
// While stalled the ROM is re-addressed with the word already in flight,
// so the word at instr keeps matching instr_pc.

module fetch_stage
	import core_cfg_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic stall,
	input logic redirect,
	input logic hold,
	input word_t pgm_data,
	input word_t target,
	output word_t pgm_addr,
	output word_t instr,
	output word_t instr_pc,
	output logic squash
);

	word_t pc; // Address the ROM samples at the next edge

	assign pgm_addr = stall ? instr_pc : pc;
	assign instr = pgm_data;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= reset_vector;
			instr_pc <= reset_vector;
			squash <= 1'b1; // ROM output is not a fetched word yet
		end
		else if (!stall)
		begin
			instr_pc <= pc;
			squash <= redirect | hold; // Wrong-path or re-fetched word
			if (redirect)
				pc <= target;
			else if (!hold)
				pc <= pc + 32'd4;
		end
	end

	// Execute never asks for a jump and a load hold in one cycle
	a_no_redirect_with_hold: assert property (@(posedge clk) disable iff (rst)
		!(redirect && hold));

endmodule

// File: verilog/execute_stage.sv
// Execute stage: decode, register file, ALU, branches and the data bus.
// Loads take two cycles and RAM must return data one cycle after data_re.
// Unknown opcodes, non-word loads/stores and bad branch codes raise fault.

module execute_stage
	import core_cfg_pkg::*;
	import rv_isa_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic stall,
	input word_t instr,
	input word_t instr_pc,
	input logic squash,
	input word_t data_rdata,
	output word_t data_addr,
	output word_t data_wdata,
	output logic data_we,
	output logic data_re,
	output logic redirect,
	output word_t target,
	output logic hold,
	output logic fault
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	word_t imm_i, imm_s, imm_b, imm_j, imm_u;
	word_t rs1_val, rs2_val, alu_result, link, wb_value, rd_data;
	logic eq, lt, ltu;
	logic active, known, writes_rd, taken, rd_we;
	logic load_phase; // Second load cycle, data_rdata is valid
	logic [reg_addr_w-1:0] load_rd;
	logic [reg_addr_w-1:0] rd_idx;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_u = {instr[31:12], 12'd0};
	assign link = instr_pc + 32'd4;

	// Only a fresh, unstalled word may act
	assign active = !stall && !squash && !load_phase;

	always_comb
	begin
		known = 1'b1;
		writes_rd = 1'b0;
		taken = 1'b0;
		case (opcode)
			op_lui, op_auipc, op_imm, op_reg, op_jal, op_jalr: writes_rd = 1'b1;
			op_load, op_store: known = (funct3 == f3_word);
			op_branch:
				case (funct3)
					f3_beq: taken = eq;
					f3_bne: taken = !eq;
					f3_blt: taken = lt;
					f3_bge: taken = !lt;
					f3_bltu: taken = ltu;
					f3_bgeu: taken = !ltu;
					default: known = 1'b0;
				endcase
			default: known = 1'b0;
		endcase
	end

	always_comb
	begin
		case (opcode)
			op_jal: target = instr_pc + imm_j;
			op_jalr: target = (rs1_val + imm_i) & ~32'd1; // Clear bit 0 per spec
			default: target = instr_pc + imm_b;
		endcase
	end

	assign redirect = active && (opcode == op_jal || opcode == op_jalr
		|| (opcode == op_branch && taken));

	assign data_addr = rs1_val + ((opcode == op_store) ? imm_s : imm_i);
	assign data_wdata = rs2_val;
	assign data_we = active && known && opcode == op_store;
	assign data_re = active && known && opcode == op_load;
	assign hold = data_re; // PC waits while the load finishes
	assign fault = active && !known;

	always_comb
	begin
		case (opcode)
			op_lui: wb_value = imm_u;
			op_auipc: wb_value = instr_pc + imm_u;
			op_jal, op_jalr: wb_value = link;
			default: wb_value = alu_result;
		endcase
	end

	assign rd_data = load_phase ? data_rdata : wb_value;
	assign rd_idx = load_phase ? load_rd : instr[11:7];
	assign rd_we = load_phase ? !stall : (active && writes_rd);

	always_ff @(posedge clk)
	begin
		if (rst)
			load_phase <= 1'b0;
		else if (!stall)
			load_phase <= data_re;
		if (data_re)
			load_rd <= instr[11:7]; // Destination kept for the second cycle
	end

	reg_file i_reg_file (
		.clk(clk),
		.rs1_idx(instr[19:15]),
		.rs2_idx(instr[24:20]),
		.rd_idx(rd_idx),
		.rd_data(rd_data),
		.rd_we(rd_we),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val)
	);

	alu i_alu (
		.instr(instr),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.result(alu_result),
		.eq(eq),
		.lt(lt),
		.ltu(ltu)
	);

	// Fetch must mark the word after a jump or a load start as stale
	a_squash_after_redirect: assert property (@(posedge clk) disable iff (rst)
		(redirect || hold) |=> squash);

endmodule

// File: verilog/lite_core.sv
// Two-stage RV32I core with separate synchronous ROM and RAM buses.
// Both memories have one cycle of read latency. The RAM must hold
// data_rdata while stall is high.

module lite_core
	import core_cfg_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic stall,
	output word_t pgm_addr,
	input word_t pgm_data,
	output word_t data_addr,
	output word_t data_wdata,
	output logic data_we,
	output logic data_re,
	input word_t data_rdata,
	output logic fault
);

	word_t instr;
	word_t instr_pc;
	word_t target;
	logic squash;
	logic redirect;
	logic hold;

	fetch_stage i_fetch_stage (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.redirect(redirect),
		.hold(hold),
		.pgm_data(pgm_data),
		.target(target),
		.pgm_addr(pgm_addr),
		.instr(instr),
		.instr_pc(instr_pc),
		.squash(squash)
	);

	execute_stage i_execute_stage (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.instr(instr),
		.instr_pc(instr_pc),
		.squash(squash),
		.data_rdata(data_rdata),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_we(data_we),
		.data_re(data_re),
		.redirect(redirect),
		.target(target),
		.hold(hold),
		.fault(fault)
	);

endmodule

// File: bench/tb_clock.sv
// Clock and reset source for the testbench.
// Reset is released on a falling edge after 8 rising edges.

module tb_clock (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles = 8;

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial
	begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// File: bench/tb_lite_core.sv
// Testbench for the two-bus core. Program, expected stores and fault count
// come from bench/core_patterns.hex, read relative to the project root.
// Random stall starts once half of the expected stores have been seen.

module tb_lite_core
	import core_cfg_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int prog_words = 64;
	localparam int ram_words = 256;
	localparam int pattern_words = 128;

	logic clk;
	logic rst;
	logic stall = 1'b0;
	logic [xlen-1:0] pgm_addr;
	logic [xlen-1:0] pgm_data = '0;
	logic [xlen-1:0] data_addr;
	logic [xlen-1:0] data_wdata;
	logic [xlen-1:0] data_rdata = '0;
	logic data_we;
	logic data_re;
	logic fault;

	logic [xlen-1:0] patterns [pattern_words]; // Program, store list, fault count
	logic [xlen-1:0] rom [prog_words];
	logic [xlen-1:0] ram [ram_words];

	int store_count = 0;
	int fault_expected = 0;
	int stores_seen = 0;
	int faults_seen = 0;
	int errors = 0;
	int cycles = 0;
	int cycle_limit = 0;

	tb_clock i_tb_clock (
		.clk(clk),
		.rst(rst)
	);

	lite_core i_lite_core (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.pgm_addr(pgm_addr),
		.pgm_data(pgm_data),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_we(data_we),
		.data_re(data_re),
		.data_rdata(data_rdata),
		.fault(fault)
	);

	always @(posedge clk)
	begin
		pgm_data <= rom[pgm_addr[7:2]]; // One cycle read latency
	end

	// Read data holds until the next read strobe, also across stall
	always @(posedge clk)
	begin
		if (data_we)
			ram[data_addr[9:2]] <= data_wdata;
		if (data_re)
			data_rdata <= ram[data_addr[9:2]];
	end

	always @(negedge clk)
	begin
		if (!rst && stores_seen >= store_count / 2)
			stall <= ($urandom % 4) == 0; // About one cycle in four
		else
			stall <= 1'b0;
	end

	function automatic string test_name(input int idx);
		if (idx < 9)
			return "alu";
		else if (idx < 12)
			return "branch";
		else if (idx < 14)
			return "jump";
		return "load";
	endfunction

	// Compare the store on the bus with the next expected pair
	task automatic check_store();
		logic [xlen-1:0] exp_addr;
		logic [xlen-1:0] exp_data;
		exp_addr = patterns[prog_words + 1 + 2 * stores_seen];
		exp_data = patterns[prog_words + 2 + 2 * stores_seen];
		if (data_addr !== exp_addr)
		begin
			$display("mismatch %s store %0d address: expected %h, actual %h",
				test_name(stores_seen), stores_seen, exp_addr, data_addr);
			errors++;
		end
		if (data_wdata !== exp_data)
		begin
			$display("mismatch %s store %0d data: expected %h, actual %h",
				test_name(stores_seen), stores_seen, exp_data, data_wdata);
			errors++;
		end
		stores_seen++;
	endtask

	initial
	begin
		void'($urandom(3)); // Fixed seed for the stall sequence
		$readmemh("bench/core_patterns.hex", patterns);
		for (int i = 0; i < prog_words; i++)
			rom[i] = patterns[i];
		for (int i = 0; i < ram_words; i++)
			ram[i] = 32'h5a5a0000 | i; // Each word carries its own index
		ram[0] = 32'h13579bdf;
		ram[1] = 32'h80000001;
		store_count = patterns[prog_words];
		fault_expected = patterns[prog_words + 1 + 2 * store_count];
		cycle_limit = 4 * (prog_words + store_count) * 2; // Doubled for stall cycles

		@(negedge rst);
		while (stores_seen < store_count && cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
			if (fault)
				faults_seen++;
			if ((data_we || data_re || fault) && stall)
			begin
				$display("bus strobe or fault seen while stall was high in cycle %0d",
					cycles);
				errors++;
			end
			if (data_we)
				check_store();
		end

		if (stores_seen < store_count)
		begin
			$display("timeout: only %0d of %0d stores seen in %0d cycles",
				stores_seen, store_count, cycles);
			errors++;
		end
		if (faults_seen != fault_expected)
		begin
			$display("mismatch fault count: expected %0d, actual %0d",
				fault_expected, faults_seen);
			errors++;
		end
		$display("errors %0d, stores %0d of %0d, faults %0d, cycles %0d",
			errors, stores_seen, store_count, faults_seen, cycles);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: compile.f
verilog/core_cfg_pkg.sv
verilog/rv_isa_pkg.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/fetch_stage.sv
verilog/execute_stage.sv
verilog/lite_core.sv
bench/tb_clock.sv
bench/tb_lite_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the core and its testbench with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_lite_core -Mdir obj_dir -f compile.f \
	&& ./obj_dir/Vtb_lite_core > sim.log 2>&1 \
	|| echo "build or run did not complete"
cat sim.log 2>/dev/null
grep -qx "Done: no errors" sim.log || { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

// File: bench/core_patterns.hex
// Words 0-63 program image, eight per line. Word 64 is the store count N.
// Then N pairs of store address and store data, then the expected fault count.
00500093 FFD00113 002081B3 40208233 00409293 40115313 01C15393 00112433 // ALU setup
001134B3 0F00C513 123455B7 00001617 0072E6B3 00A37733 10302023 10402223 // LUI, AUIPC
10602423 10702623 10802823 10B02A23 10C02C23 10D02E23 12E02023 0000000B // Fault 1
00108463 1E102823 00209463 1E102823 00114463 1E102823 00116463 12A02223 // Branches
0020D463 1E102823 0020F463 12502423 00208463 12902623 008007EF 1E102823 // JAL
00C78867 1E102823 12F02823 13002A23 00002883 13102C23 00402903 011909B3 // JALR, loads
13302E23 FFFFFFFF 15202023 11402A03 15402223 0000006F 00000013 00000013 // Fault 2, end
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000012
00000100 00000002 00000104 00000008
00000108 FFFFFFFE 0000010C 0000000F
00000110 00000001 00000114 12345000
00000118 0000102C 0000011C 0000005F
00000120 000000F4 00000124 000000F5
00000128 00000050 0000012C 00000000
00000130 0000009C 00000134 000000A4
00000138 13579BDF 0000013C 93579BE0
00000140 80000001 00000144 12345000
00000002
